//--- Bender.yml
package:
  name: prf

export_include_dirs:
  - src

sources:
  - target: rtl
    include_dirs:
      - src
    files:
      - src/prf_pkg.sv
      - src/prf_wb_stage.sv
      - src/prf_ff.sv
      - src/prf_read_stage.sv
      - src/prf_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/prf_tb.sv

//--- dv/prf_tb.sv
/*
    testbench for the physical register file
    - clock, reset and falling-edge stimulus
    - shadow register model with a two-deep expected pipeline
    - concurrent response checks per read requester
    - directed phases and a seeded random phase
*/

`timescale 1ns/1ps

`include "prf_config.svh"

module prf_tb
    import prf_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int RESET_LEN   = 8;
    localparam int RAND_CYCLES = 400;
    localparam int SEED        = 32'h746b5c85;

    logic             CLK;
    logic             nRST;
    prf_wb_vec_t      wb_req;
    prf_rd_idx_vec_t  rd_req;
    prf_rd_data_vec_t rd_resp;

    // model state
    prf_data_t        shadow [`PRF_PR_COUNT];
    prf_rd_data_vec_t exp_mid;
    prf_rd_data_vec_t exp_resp;
    int               cycle_cnt;

    prf_top prf_top_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .wb_req  (wb_req),
        .rd_req  (rd_req),
        .rd_resp (rd_resp)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ------------------------------
    // reference model
    // ------------------------------

    // writes land in the shadow first, so same-cycle reads see them
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int p = 0; p < `PRF_PR_COUNT; p++) begin
                shadow[p] = '0;
            end
            exp_mid   <= '0;
            exp_resp  <= '0;
            cycle_cnt <= 0;
        end else begin
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                if (wb_req[w].valid) begin
                    shadow[wb_req[w].pr] = wb_req[w].data;
                end
            end
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                exp_mid[r] <= shadow[rd_req[r]];
            end
            exp_resp  <= exp_mid;
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // ------------------------------
    // response checks
    // ------------------------------

    for (genvar r = 0; r < `PRF_RR_COUNT; r++) begin : g_resp_chk
        a_resp_match : assert property (
            @(posedge CLK) disable iff (!nRST)
            rd_resp[r] == exp_resp[r]
        ) else begin
            $display("Error: time %0t signal rd_resp[%0d] got %h expected %h",
                     $time, r, $sampled(rd_resp[r]), $sampled(exp_resp[r]));
            $display("*** FAILED ***");
            $fatal(1, "read response mismatch");
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1, "wait timed out");
    endtask

    // n falling edges, bounded in simulated time
    task automatic wait_negedges(input int n, input string what);
        int  cnt;
        time start_t;
        cnt     = 0;
        start_t = $time;
        while (cnt < n) begin
            @(negedge CLK);
            cnt++;
            if ($time - start_t > (n + 2) * CLK_PERIOD) begin
                fail_timeout(what);
            end
        end
    endtask

    task automatic clear_inputs();
        wb_req = '0;
        rd_req = '0;
    endtask

    task automatic set_write(input int w, input int pr, input prf_data_t data, input logic valid);
        wb_req[w].valid = valid;
        wb_req[w].pr    = pr_idx_t'(pr);
        wb_req[w].data  = data;
    endtask

    // odd stride over a power-of-two count keeps writers on distinct rows
    task automatic random_cycle();
        int base;
        int stride;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            wb_req[w].valid = 1'($urandom_range(0, 1));
            wb_req[w].data  = $urandom;
        end
        base   = $urandom % `PRF_PR_COUNT;
        stride = ($urandom % `PRF_PR_COUNT) | 1;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            wb_req[w].pr = pr_idx_t'((base + w * stride) % `PRF_PR_COUNT);
        end
        // reads lean toward rows being written to hit the bypass
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            if ($urandom_range(0, 2) == 0) begin
                rd_req[r] = wb_req[$urandom % `PRF_WR_COUNT].pr;
            end else begin
                rd_req[r] = pr_idx_t'($urandom % `PRF_PR_COUNT);
            end
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        int target;
        int guard;
        nRST   = 1'b0;
        wb_req = '0;
        rd_req = '0;
        void'($urandom(SEED));

        wait_negedges(RESET_LEN, "reset cycles");
        nRST = 1'b1;

        // every register reads zero after reset
        for (int base = 0; base < `PRF_PR_COUNT; base += `PRF_RR_COUNT) begin
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                rd_req[r] = pr_idx_t'((base + r) % `PRF_PR_COUNT);
            end
            wait_negedges(1, "reset readout");
        end
        clear_inputs();

        // plain write then later read, plus a write with valid low
        set_write(0, 5, 32'hdead_beef, 1'b1);
        set_write(1, 9, 32'h1234_5678, 1'b0);
        wait_negedges(1, "single write");
        clear_inputs();
        wait_negedges(3, "write settle");
        rd_req[0] = pr_idx_t'(5);
        rd_req[1] = pr_idx_t'(9);
        wait_negedges(1, "single readback");
        clear_inputs();

        // same-cycle read through the bypass, then from storage
        set_write(1, 12, 32'hcafe_f00d, 1'b1);
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            rd_req[r] = pr_idx_t'(12);
        end
        wait_negedges(1, "same-cycle forward");
        wb_req = '0;
        wait_negedges(2, "storage readback");
        clear_inputs();

        // both writers on different rows, read back on all requesters
        set_write(0, 20, 32'h0bad_0001, 1'b1);
        set_write(1, 33, 32'h0bad_0002, 1'b1);
        wait_negedges(1, "dual write");
        wb_req = '0;
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            rd_req[r] = pr_idx_t'((r % 2 == 0) ? 20 : 33);
        end
        wait_negedges(3, "dual readback");
        clear_inputs();

        for (int c = 0; c < RAND_CYCLES; c++) begin
            random_cycle();
            wait_negedges(1, "random traffic");
        end
        clear_inputs();

        // let the last reads leave the pipeline
        target = cycle_cnt + 3;
        guard  = 0;
        while (cycle_cnt < target) begin
            @(negedge CLK);
            guard++;
            if (guard > 10) begin
                fail_timeout("pipeline drain");
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/prf_pkg.sv
src/prf_wb_stage.sv
src/prf_ff.sv
src/prf_read_stage.sv
src/prf_top.sv
dv/prf_tb.sv

//--- src/prf_config.svh
/*
    physical register file configuration
    - register count and index width
    - read and write requester counts
    - register data width
*/

`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

// number of physical registers, power of two from 8 up
`define PRF_PR_COUNT 64

// index width, log2 of the register count
`define PRF_LOG_PR_COUNT 6

// requesters served every cycle
`define PRF_RR_COUNT 4
`define PRF_WR_COUNT 2

// register word, fixed at 32
`define PRF_DATA_WIDTH 32

`endif

//--- src/prf_ff.sv
/*
    flop storage for the physical register file
    - one 32-bit row per physical register
    - per-row write enable from the writeback stage
    - all rows exposed for the read stage mux
*/

`timescale 1ns/1ps

`include "prf_config.svh"

module prf_ff
    import prf_pkg::*;
(
    input  logic                             CLK,
    input  logic                             nRST,

    // decoded writes, at most one writer per row
    input  logic [`PRF_PR_COUNT-1:0]         wr_en,
    input  prf_data_t [`PRF_PR_COUNT-1:0]    wr_data,

    // full storage contents
    output prf_data_t [`PRF_PR_COUNT-1:0]    rows
);

    // ------------------------------
    // storage array
    // ------------------------------

    // architectural state after reset is all zero
    prf_data_t [`PRF_PR_COUNT-1:0] mem_q;

    // next value per row, old contents held when not enabled
    prf_data_t [`PRF_PR_COUNT-1:0] mem_d;

    always_comb begin
        mem_d = mem_q;
        for (int p = 0; p < `PRF_PR_COUNT; p++) begin
            if (wr_en[p]) begin
                mem_d[p] = wr_data[p];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_q <= '0;
        end else begin
            mem_q <= mem_d;
        end
    end

    // ------------------------------
    // row read
    // ------------------------------

    // no mux here, the read stage picks rows per requester
    assign rows = mem_q;

endmodule

//--- src/prf_pkg.sv
/*
    shared types for the physical register file
    - register index and data word
    - writeback request struct
    - per-requester vectors for writeback, read index and read data
*/

`include "prf_config.svh"

package prf_pkg;

    // ------------------------------
    // scalar types
    // ------------------------------

    // physical register index
    typedef logic [`PRF_LOG_PR_COUNT-1:0] pr_idx_t;

    // one register word
    typedef logic [`PRF_DATA_WIDTH-1:0] prf_data_t;

    // ------------------------------
    // writeback request
    // ------------------------------

    typedef struct packed {
        logic      valid;
        pr_idx_t   pr;
        prf_data_t data;
    } prf_wb_t;

    // ------------------------------
    // per-requester vectors
    // ------------------------------

    typedef prf_wb_t [`PRF_WR_COUNT-1:0] prf_wb_vec_t;
    typedef pr_idx_t [`PRF_RR_COUNT-1:0] prf_rd_idx_vec_t;
    typedef prf_data_t [`PRF_RR_COUNT-1:0] prf_rd_data_vec_t;

endpackage

//--- src/prf_read_stage.sv
/*
    read output stage
    - boundary register for read indices
    - row select per read requester
    - bypass from staged writebacks not yet in storage
    - response register, two cycles after the index
*/

`timescale 1ns/1ps

`include "prf_config.svh"

module prf_read_stage
    import prf_pkg::*;
(
    input  logic                             CLK,
    input  logic                             nRST,

    // read indices, one per requester, every cycle
    input  prf_rd_idx_vec_t                  rd_req,

    // storage contents
    input  prf_data_t [`PRF_PR_COUNT-1:0]    rows,

    // staged writebacks, one cycle ahead of storage
    input  prf_wb_vec_t                      wb_q,

    // read data, one per requester
    output prf_rd_data_vec_t                 rd_resp
);

    // ------------------------------
    // index register
    // ------------------------------

    prf_rd_idx_vec_t rd_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_q <= '0;
        end else begin
            rd_q <= rd_req;
        end
    end

    // ------------------------------
    // select and bypass
    // ------------------------------

    prf_rd_data_vec_t rd_sel;

    // row first, then any staged write to the same register wins
    // since storage only sees that write at the coming edge
    always_comb begin
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            rd_sel[r] = rows[rd_q[r]];
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                if (wb_q[w].valid && (wb_q[w].pr == rd_q[r])) begin
                    rd_sel[r] = wb_q[w].data;
                end
            end
        end
    end

    // ------------------------------
    // response register
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_resp <= '0;
        end else begin
            rd_resp <= rd_sel;
        end
    end

    // index range only matters when the count leaves unused codes
    if ((1 << `PRF_LOG_PR_COUNT) != `PRF_PR_COUNT) begin : g_idx_chk
        for (genvar r = 0; r < `PRF_RR_COUNT; r++) begin : g_rr
            a_idx_range : assert property (
                @(posedge CLK) disable iff (!nRST)
                rd_q[r] < `PRF_PR_COUNT
            ) else begin
                $error("read requester %0d index %0d out of range", r, rd_q[r]);
            end
        end
    end

endmodule

//--- src/prf_top.sv
/*
    physical register file top
    - writeback stage, flop storage and read stage
    - two-cycle read latency, writes visible to same-cycle reads
*/

`timescale 1ns/1ps

`include "prf_config.svh"

module prf_top
    import prf_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,

    // writeback requests
    input  prf_wb_vec_t       wb_req,

    // read indices and responses
    input  prf_rd_idx_vec_t   rd_req,
    output prf_rd_data_vec_t  rd_resp
);

    // ------------------------------
    // internal nets
    // ------------------------------

    prf_wb_vec_t                      wb_q;
    logic [`PRF_PR_COUNT-1:0]         wr_en;
    prf_data_t [`PRF_PR_COUNT-1:0]    wr_data;
    prf_data_t [`PRF_PR_COUNT-1:0]    rows;

    // ------------------------------
    // stages
    // ------------------------------

    prf_wb_stage prf_wb_stage_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .wb_req  (wb_req),
        .wb_q    (wb_q),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    prf_ff prf_ff_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rows    (rows)
    );

    // bypass path uses the staged writes directly
    prf_read_stage prf_read_stage_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .rd_req  (rd_req),
        .rows    (rows),
        .wb_q    (wb_q),
        .rd_resp (rd_resp)
    );

endmodule

//--- src/prf_wb_stage.sv
/*
    writeback input stage
    - boundary register for all write requesters
    - decode of staged writes into per-row enable and data
    - check for two writers hitting one register
*/

`timescale 1ns/1ps

`include "prf_config.svh"

module prf_wb_stage
    import prf_pkg::*;
(
    input  logic                             CLK,
    input  logic                             nRST,

    // writeback requests from the execution pipes
    input  prf_wb_vec_t                      wb_req,

    // staged copy, also used for forwarding on the read side
    output prf_wb_vec_t                      wb_q,

    // per-row write controls to storage
    output logic [`PRF_PR_COUNT-1:0]         wr_en,
    output prf_data_t [`PRF_PR_COUNT-1:0]    wr_data
);

    // ------------------------------
    // boundary register
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_req;
        end
    end

    // ------------------------------
    // row decode
    // ------------------------------

    // each valid writer sets the bit of the row it names
    // writers never share a row so the loop order does not matter
    always_comb begin
        wr_en   = '0;
        wr_data = '0;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            if (wb_q[w].valid) begin
                wr_en[wb_q[w].pr]   = 1'b1;
                wr_data[wb_q[w].pr] = wb_q[w].data;
            end
        end
    end

    // ------------------------------
    // writer conflict check
    // ------------------------------

    // every pair of writers, flagged at presentation
    for (genvar a = 0; a < `PRF_WR_COUNT; a++) begin : g_wr_a
        for (genvar b = a + 1; b < `PRF_WR_COUNT; b++) begin : g_wr_b
            a_no_dup_wr : assert property (
                @(posedge CLK) disable iff (!nRST)
                !(wb_req[a].valid && wb_req[b].valid && (wb_req[a].pr == wb_req[b].pr))
            ) else begin
                $error("writers %0d and %0d both target pr %0d", a, b, wb_req[a].pr);
            end
        end
    end

endmodule
